// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_board_spi
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line appears in the simulator output
run: compile
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/board_spi_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module board_spi_top (
  input  logic                 spi_csn,
  input  logic                 spi_clk,
  input  logic                 spi_mosi,
  output logic                 spi_miso,
  inout  wire                  spi_sdio,
  output cpld_regs_pkg::ctrl_t board_ctrl
);

  // frame position shared by both blocks
  spi_bus_pkg::frame_count_t bit_count;
  logic                      cpld_sel;
  logic                      sdio_release;
  logic                      cpld_miso;

  // ******************************
  // frame decode
  // ******************************

  sdio_turnaround i_turnaround (
    .spi_csn      (spi_csn),
    .spi_clk      (spi_clk),
    .spi_mosi     (spi_mosi),
    .bit_count    (bit_count),
    .cpld_sel     (cpld_sel),
    .sdio_release (sdio_release)
  );

  // internal register bank
  cpld_reg_slave i_regs (
    .spi_csn    (spi_csn),
    .spi_clk    (spi_clk),
    .spi_mosi   (spi_mosi),
    .bit_count  (bit_count),
    .cpld_sel   (cpld_sel),
    .cpld_miso  (cpld_miso),
    .board_ctrl (board_ctrl)
  );

  // ******************************
  // pad logic
  // ******************************

  // host data passes through until the chip owns the line
  assign spi_sdio = sdio_release ? 1'bz : spi_mosi;

  // bank answers itself, chips answer over sdio
  assign spi_miso = cpld_sel ? cpld_miso : spi_sdio;

endmodule

`default_nettype wire

// ==== rtl/cpld_reg_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpld_reg_slave (
  input  logic                      spi_csn,
  input  logic                      spi_clk,
  input  logic                      spi_mosi,
  input  spi_bus_pkg::frame_count_t bit_count,
  input  logic                      cpld_sel,
  output logic                      cpld_miso,
  output cpld_regs_pkg::ctrl_t      board_ctrl
);

  cpld_regs_pkg::reg_state_t state;
  // rw flag in bit 7, address below it
  logic [7:0]                hdr_shift;
  logic                      rd_wr_n;
  cpld_regs_pkg::reg_addr_t  reg_addr;
  // first 7 data bits, the 8th comes straight from mosi at commit
  logic [6:0]                wr_shift;
  logic                      wr_commit;
  // storage keeps its value across frames
  cpld_regs_pkg::reg_data_t  scratch_reg;
  cpld_regs_pkg::reg_data_t  control_reg;
  cpld_regs_pkg::reg_data_t  rd_data;
  cpld_regs_pkg::reg_data_t  rd_shift;

  assign rd_wr_n  = hdr_shift[7];
  assign reg_addr = hdr_shift[6:0];

  // ******************************
  // phase tracking and header
  // ******************************

  always_ff @(posedge spi_clk or posedge spi_csn) begin
    if (spi_csn) begin
      state     <= cpld_regs_pkg::st_addr;
      hdr_shift <= '0;
    end else begin
      case (state)
        cpld_regs_pkg::st_addr: begin
          // bits 8 to 15 are rw flag plus address
          if (bit_count >= spi_bus_pkg::rw_bit_pos) begin
            hdr_shift <= {hdr_shift[6:0], spi_mosi};
          end
          if (bit_count == spi_bus_pkg::turn_short - 6'd1) begin
            state <= cpld_regs_pkg::st_data;
          end
        end
        cpld_regs_pkg::st_data: begin
          // data byte ends at bit 23
          if (bit_count == spi_bus_pkg::turn_short + 6'd7) begin
            state <= cpld_regs_pkg::st_done;
          end
        end
        cpld_regs_pkg::st_done: state <= cpld_regs_pkg::st_done;
        default: state <= cpld_regs_pkg::st_addr;
      endcase
    end
  end

  // ******************************
  // serial write
  // ******************************

  always_ff @(posedge spi_clk) begin
    if (state == cpld_regs_pkg::st_data) begin
      wr_shift <= {wr_shift[5:0], spi_mosi};
    end
  end

  // commit on the edge that samples bit 23, count reads 24 afterwards
  assign wr_commit = cpld_sel && !rd_wr_n && (state == cpld_regs_pkg::st_data) &&
                     (bit_count == spi_bus_pkg::turn_short + 6'd7);

  always_ff @(posedge spi_clk) begin
    if (wr_commit) begin
      case (reg_addr)
        cpld_regs_pkg::reg_scratch: scratch_reg <= {wr_shift, spi_mosi};
        cpld_regs_pkg::reg_control: control_reg <= {wr_shift, spi_mosi};
        // version and unmapped addresses drop the write
        default: ;
      endcase
    end
  end

  // board lines follow the low control bits
  assign board_ctrl = control_reg[2:0];

  // ******************************
  // serial read
  // ******************************

  always_comb begin
    case (reg_addr)
      cpld_regs_pkg::reg_version: rd_data = cpld_regs_pkg::version_value;
      cpld_regs_pkg::reg_scratch: rd_data = scratch_reg;
      cpld_regs_pkg::reg_control: rd_data = control_reg;
      default: rd_data = '0;
    endcase
  end

  // load at bit 16, then one bit per falling edge
  always_ff @(negedge spi_clk or posedge spi_csn) begin
    if (spi_csn) begin
      rd_shift <= '0;
    end else if (state == cpld_regs_pkg::st_data) begin
      if (rd_wr_n && (bit_count == spi_bus_pkg::turn_short)) begin
        rd_shift <= rd_data;
      end else begin
        rd_shift <= {rd_shift[6:0], 1'b0};
      end
    end else begin
      // idle low outside the data byte
      rd_shift <= '0;
    end
  end

  assign cpld_miso = rd_shift[7];

  // any change in storage traces back to a frame aimed at this bank
  a_commit_selected: assert property (
    @(posedge spi_clk)
    ($changed(scratch_reg) || $changed(control_reg)) |-> $past(cpld_sel)
  );

endmodule

`default_nettype wire

// ==== rtl/cpld_regs_pkg.sv ====
`default_nettype none

package cpld_regs_pkg;

  // ******************************
  // register bank layout
  // ******************************

  // 7-bit address follows the read/write flag
  typedef logic [6:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  // board control lines taken from the control register
  typedef logic [2:0] ctrl_t;

  localparam reg_addr_t reg_version = 7'd0;
  localparam reg_addr_t reg_scratch = 7'd1;
  localparam reg_addr_t reg_control = 7'd2;

  // read-only, writes are dropped
  localparam reg_data_t version_value = 8'h21;

  // bank phase within a frame
  // st_addr covers select byte, rw flag and address
  typedef enum logic [1:0] {
    st_addr,
    st_data,
    st_done
  } reg_state_t;

endpackage

`default_nettype wire

// ==== rtl/sdio_turnaround.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdio_turnaround (
  input  logic                      spi_csn,
  input  logic                      spi_clk,
  input  logic                      spi_mosi,
  output spi_bus_pkg::frame_count_t bit_count,
  output logic                      cpld_sel,
  output logic                      sdio_release
);

  // captured select byte, msb first
  spi_bus_pkg::dev_sel_t     dev_sel;
  // high for a read frame
  logic                      rd_wr_n;
  // turnaround point of the selected device
  spi_bus_pkg::frame_count_t turn_count;
  // low for an unknown select code
  logic                      turn_valid;

  // ******************************
  // rising edge, sample side
  // ******************************

  always_ff @(posedge spi_clk or posedge spi_csn) begin
    if (spi_csn) begin
      bit_count <= '0;
      dev_sel   <= '0;
      rd_wr_n   <= 1'b0;
      cpld_sel  <= 1'b0;
    end else begin
      // count up, hold at 63
      if (bit_count != 6'h3f) begin
        bit_count <= bit_count + 6'd1;
      end
      // bits 0 to 7 form the select byte
      if (bit_count < spi_bus_pkg::rw_bit_pos) begin
        dev_sel <= {dev_sel[6:0], spi_mosi};
      end
      // last select bit arrives now, decide bank select on the full byte
      if (bit_count == spi_bus_pkg::rw_bit_pos - 6'd1) begin
        cpld_sel <= ({dev_sel[6:0], spi_mosi} == spi_bus_pkg::sel_cpld);
      end
      // bit 8 is the read/write flag
      if (bit_count == spi_bus_pkg::rw_bit_pos) begin
        rd_wr_n <= spi_mosi;
      end
    end
  end

  // per-device turnaround lookup
  always_comb begin
    turn_valid = 1'b1;
    case (dev_sel)
      spi_bus_pkg::sel_adc,
      spi_bus_pkg::sel_clk: turn_count = spi_bus_pkg::turn_long;
      spi_bus_pkg::sel_dac,
      spi_bus_pkg::sel_cpld: turn_count = spi_bus_pkg::turn_short;
      default: begin
        turn_count = '0;
        turn_valid = 1'b0;
      end
    endcase
  end

  // ******************************
  // falling edge, drive side
  // ******************************

  // sdio release latches until the frame ends
  // writes and unknown devices keep the bridge driving
  always_ff @(negedge spi_clk or posedge spi_csn) begin
    if (spi_csn) begin
      sdio_release <= 1'b0;
    end else if (turn_valid && rd_wr_n && (bit_count == turn_count)) begin
      sdio_release <= 1'b1;
    end
  end

  // bus handed over only after a read flag was seen
  a_release_on_read: assert property (
    @(negedge spi_clk) disable iff (spi_csn)
    $rose(sdio_release) |-> rd_wr_n
  );

  // saturation holds for the rest of the frame
  a_count_saturates: assert property (
    @(posedge spi_clk) disable iff (spi_csn)
    (bit_count == 6'h3f) |=> (bit_count == 6'h3f)
  );

endmodule

`default_nettype wire

// ==== rtl/spi_bus_pkg.sv ====
`default_nettype none

package spi_bus_pkg;

  // ******************************
  // frame layout types
  // ******************************

  // first byte of every frame picks the target device
  typedef logic [7:0] dev_sel_t;

  // bit counter, saturates at 63 so long frames never wrap
  typedef logic [5:0] frame_count_t;

  // ******************************
  // device select codes
  // ******************************

  localparam dev_sel_t sel_adc  = 8'h80;
  localparam dev_sel_t sel_dac  = 8'h81;
  localparam dev_sel_t sel_clk  = 8'h82;
  // register bank inside the bridge itself
  localparam dev_sel_t sel_cpld = 8'h83;

  // bit count at which sdio is handed to the chip on a read
  // adc and clock chip use a 16-bit instruction after the select byte
  localparam frame_count_t turn_long  = 6'd24;
  // dac and register bank use an 8-bit instruction
  localparam frame_count_t turn_short = 6'd16;

  // read/write flag follows the select byte directly, high means read
  localparam frame_count_t rw_bit_pos = 6'd8;

endpackage

`default_nettype wire

// ==== verification/tb_spi_tasks.svh ====
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// ******************************
// stimulus and reporting
// ******************************

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// one lfsr step per bit, first bit taken lands in the msb
task automatic take_byte(output logic [7:0] b);
  int i;
  b = 8'h00;
  for (i = 0; i < 8; i++) begin
    b = {b[6:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
endtask

task automatic abort_run(input string why);
  $display("%s", why);
  $display("TEST FAILED");
  $fatal(1, "stopped at first error");
endtask

task automatic value_error(input string name, input logic [7:0] got, input logic [7:0] want);
  abort_run($sformatf("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want));
endtask

// select byte, rw flag, 7-bit address, data byte, zero padding
function automatic logic [31:0] frame_word(input logic [7:0] sel, input logic rw,
                                           input logic [6:0] addr, input logic [7:0] data);
  return {sel, rw, addr, data, 8'h00};
endfunction

// ******************************
// frame driver
// ******************************

// exp_rel is the bit where the chip should own sdio, -1 for never
// via_sdio means miso has to mirror sdio for the whole frame
task automatic run_frame(input logic [31:0] tx, input int nbits, input int exp_rel,
                         input logic [7:0] rx, input logic via_sdio);
  logic [31:0] tx_sr;
  logic [7:0]  rx_sr;
  logic        sent;
  int          n;
  tx_sr = tx;
  rx_sr = rx;
  sent  = tx_sr[31];
  @(posedge spi_clk);
  spi_csn  <= 1'b0;
  spi_mosi <= sent;
  cur_bit   = 0;
  for (n = 0; n < nbits; n++) begin
    // bit n sampled on this edge
    @(posedge spi_clk);
    if (exp_rel < 0 || n < exp_rel) begin
      assert (spi_sdio === sent) else value_error("spi_sdio", 8'(spi_sdio), 8'(sent));
    end else if (n < exp_rel + 8) begin
      assert (spi_miso === rx_sr[7]) else value_error("spi_miso", 8'(spi_miso), 8'(rx_sr[7]));
      rx_sr = rx_sr << 1;
    end
    if (via_sdio) begin
      assert (spi_miso === spi_sdio) else value_error("spi_miso", 8'(spi_miso), 8'(spi_sdio));
    end
    checks_done++;
    tx_sr     = tx_sr << 1;
    sent      = tx_sr[31];
    spi_mosi <= sent;
    cur_bit   = n + 1;
  end
  spi_csn  <= 1'b1;
  spi_mosi <= 1'b0;
  repeat (2) @(posedge spi_clk);
  assert (chip_seen == exp_rel) else abort_run($sformatf(
    "sdio handed to the chip at bit %0d, expected bit %0d (-1 is never)", chip_seen, exp_rel));
endtask

task automatic check_ctrl();
  assert (board_ctrl === ctrl_expect)
    else value_error("board_ctrl", 8'(board_ctrl), 8'(ctrl_expect));
  checks_done++;
endtask

// ******************************
// directed tests
// ******************************

task automatic adc_write_passes();
  logic [7:0] d;
  take_byte(d);
  run_frame(frame_word(spi_bus_pkg::sel_adc, 1'b0, 7'h0a, d), 24, -1, 8'h00, 1'b1);
endtask

// dac hands over after its 8-bit instruction, at bit 16
task automatic dac_read_turnaround();
  take_byte(chip_byte);
  run_frame(frame_word(spi_bus_pkg::sel_dac, 1'b1, 7'h05, 8'h00), 24, 16, chip_byte, 1'b1);
endtask

// clock chip has a 16-bit instruction, so bits 16 to 23 still come from the host
task automatic clk_read_late_turnaround();
  take_byte(chip_byte);
  run_frame(frame_word(spi_bus_pkg::sel_clk, 1'b1, 7'h12, 8'h00), 32, 24, chip_byte, 1'b1);
endtask

task automatic scratch_readback();
  logic [7:0] d;
  take_byte(d);
  run_frame(frame_word(spi_bus_pkg::sel_cpld, 1'b0, cpld_regs_pkg::reg_scratch, d),
            24, -1, 8'h00, 1'b0);
  run_frame(frame_word(spi_bus_pkg::sel_cpld, 1'b1, cpld_regs_pkg::reg_scratch, 8'h00),
            24, 16, d, 1'b0);
  run_frame(frame_word(spi_bus_pkg::sel_cpld, 1'b1, cpld_regs_pkg::reg_version, 8'h00),
            24, 16, 8'h21, 1'b0);
endtask

task automatic control_lines_hold();
  logic [7:0] d;
  take_byte(d);
  run_frame(frame_word(spi_bus_pkg::sel_cpld, 1'b0, cpld_regs_pkg::reg_control, d),
            24, -1, 8'h00, 1'b0);
  ctrl_expect = d[2:0];
  check_ctrl();
  // traffic to another chip on the control address leaves the lines alone
  run_frame(frame_word(spi_bus_pkg::sel_adc, 1'b0, cpld_regs_pkg::reg_control, ~d),
            24, -1, 8'h00, 1'b1);
  check_ctrl();
  // version is read-only
  run_frame(frame_word(spi_bus_pkg::sel_cpld, 1'b0, cpld_regs_pkg::reg_version, ~d),
            24, -1, 8'h00, 1'b0);
  run_frame(frame_word(spi_bus_pkg::sel_cpld, 1'b1, cpld_regs_pkg::reg_version, 8'h00),
            24, 16, 8'h21, 1'b0);
  check_ctrl();
endtask

task automatic unknown_select_ignored();
  run_frame(frame_word(8'h90, 1'b1, 7'h01, 8'h00), 24, -1, 8'h00, 1'b1);
  check_ctrl();
endtask

`endif

// ==== verification/tb_board_spi.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_board_spi;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 8;
  // eleven frames in the sequence, each given 30 cycles
  localparam int num_frames   = 11;
  localparam int watchdog_ns  = (reset_cycles + num_frames * 30) * clk_period;
  // chip clock-to-out after the falling edge
  localparam int chip_tco     = 5;

  logic                 spi_csn;
  logic                 spi_clk;
  logic                 spi_mosi;
  logic                 spi_miso;
  wire                  spi_sdio;
  cpld_regs_pkg::ctrl_t board_ctrl;

  // chip model on the shared line
  logic       sdio_en    = 1'b0;
  logic       sdio_drv   = 1'b0;
  logic       chip_busy  = 1'b0;
  logic [7:0] chip_shift = 8'h00;
  logic [7:0] chip_byte;
  // bit on mosi when the chip saw the release, -1 for none
  int         chip_seen  = -1;
  // frame bit currently on mosi
  int         cur_bit    = 0;
  int         checks_done;
  logic [15:0] lfsr_state;
  // last value written to the control register
  logic [2:0] ctrl_expect;

  board_spi_top i_dut (
    .spi_csn    (spi_csn),
    .spi_clk    (spi_clk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso),
    .spi_sdio   (spi_sdio),
    .board_ctrl (board_ctrl)
  );

  assign spi_sdio = sdio_en ? sdio_drv : 1'bz;
  // released line floats high, host sends zeros after the turnaround
  pullup (spi_sdio);

  `include "tb_spi_tasks.svh"

  initial begin : clock_gen
    spi_clk = 1'b0;
    forever begin
      #(clk_period / 2) spi_clk = ~spi_clk;
    end
  end

  // ******************************
  // chip model
  // ******************************

  // takes the line once it stops following mosi, then shifts its byte out msb first
  always begin : chip_model
    @(negedge spi_clk);
    #chip_tco;
    if (spi_csn) begin
      chip_busy = 1'b0;
      sdio_en  <= 1'b0;
    end else if (cur_bit == 0) begin
      // new frame
      chip_seen = -1;
    end else if (chip_busy) begin
      chip_shift = chip_shift << 1;
      sdio_drv  <= chip_shift[7];
    end else if (chip_seen < 0 && spi_sdio !== spi_mosi) begin
      chip_seen  = cur_bit;
      chip_busy  = 1'b1;
      chip_shift = chip_byte;
      sdio_drv  <= chip_shift[7];
      sdio_en   <= 1'b1;
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    abort_run($sformatf("Timeout: test sequence still running after %0d ns", watchdog_ns));
  end

  initial begin : test_sequence
    spi_csn    <= 1'b1;
    spi_mosi   <= 1'b0;
    chip_byte   = 8'h00;
    checks_done = 0;
    ctrl_expect = 3'b000;
    lfsr_state  = 16'd36323;
    // frame reset held by csn
    repeat (reset_cycles) @(posedge spi_clk);
    adc_write_passes();
    dac_read_turnaround();
    clk_read_late_turnaround();
    scratch_readback();
    control_lines_hold();
    unknown_select_ignored();
    if (checks_done > 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("no checks were run");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verification
rtl/spi_bus_pkg.sv
rtl/cpld_regs_pkg.sv
rtl/sdio_turnaround.sv
rtl/cpld_reg_slave.sv
rtl/board_spi_top.sv
verification/tb_board_spi.sv
